//--- all.f
hdl/nice_isa_pkg.sv
hdl/nice_icb_pkg.sv
hdl/nice_rowbuf.sv
hdl/nice_seq.sv
hdl/nice_core.sv
sim/tb_nice_mem.sv
sim/tb_nice_core.sv

//--- hdl/nice_core.sv
// nice coprocessor top: joins the sequencer and the row buffer to the core and icb ports
`timescale 1ns/1ps
`default_nettype none

module nice_core #(
   parameter int unsigned row_len = 3
) (
   input  wire logic                                nice_clk,
   input  wire logic                                nice_rst_n,
   output logic                                     nice_active,
   output logic                                     nice_mem_holdup,
   // request channel
   input  wire logic                                nice_req_valid,
   output logic                                     nice_req_ready,
   input  wire logic [nice_isa_pkg::XLEN-1:0]       nice_req_inst,
   input  wire logic [nice_isa_pkg::XLEN-1:0]       nice_req_rs1,
   // response channel
   output logic                                     nice_rsp_valid,
   input  wire logic                                nice_rsp_ready,
   output logic [nice_isa_pkg::XLEN-1:0]            nice_rsp_rdat,
   output logic                                     nice_rsp_err,
   // icb command
   output logic                                     nice_icb_cmd_valid,
   input  wire logic                                nice_icb_cmd_ready,
   output logic [nice_icb_pkg::ADDR_W-1:0]          nice_icb_cmd_addr,
   output logic                                     nice_icb_cmd_read,
   output logic [nice_isa_pkg::XLEN-1:0]            nice_icb_cmd_wdata,
   output logic [1:0]                               nice_icb_cmd_size,
   // icb response
   input  wire logic                                nice_icb_rsp_valid,
   output logic                                     nice_icb_rsp_ready,
   input  wire logic [nice_isa_pkg::XLEN-1:0]       nice_icb_rsp_rdata,
   input  wire logic                                nice_icb_rsp_err
);

   localparam int unsigned idx_w = (row_len > 1) ? $clog2(row_len) : 1;

   // sequencer to row buffer
   logic                            load_wr;
   logic                            sum_wr;
   logic [idx_w-1:0]                wr_idx;
   logic [idx_w-1:0]                rd_idx;
   logic [nice_isa_pkg::XLEN-1:0]   row_sum;

   ////////////////////////////////////////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////////////////////////////////////////
   nice_seq #(
      .row_len (row_len)
   ) u_nice_seq (
      .nice_clk           (nice_clk),
      .nice_rst_n         (nice_rst_n),
      .nice_req_valid     (nice_req_valid),
      .nice_req_ready     (nice_req_ready),
      .nice_req_inst      (nice_req_inst),
      .nice_req_rs1       (nice_req_rs1),
      .nice_rsp_valid     (nice_rsp_valid),
      .nice_rsp_ready     (nice_rsp_ready),
      .nice_rsp_rdat      (nice_rsp_rdat),
      .nice_rsp_err       (nice_rsp_err),
      .nice_icb_cmd_valid (nice_icb_cmd_valid),
      .nice_icb_cmd_ready (nice_icb_cmd_ready),
      .nice_icb_cmd_addr  (nice_icb_cmd_addr),
      .nice_icb_cmd_read  (nice_icb_cmd_read),
      .nice_icb_rsp_valid (nice_icb_rsp_valid),
      .nice_icb_rsp_err   (nice_icb_rsp_err),
      .load_wr            (load_wr),
      .sum_wr             (sum_wr),
      .wr_idx             (wr_idx),
      .rd_idx             (rd_idx),
      .row_sum            (row_sum),
      .nice_active        (nice_active),
      .nice_mem_holdup    (nice_mem_holdup)
   );

   ////////////////////////////////////////////////////////////////////////////
   // row buffer, its read port feeds the store data
   ////////////////////////////////////////////////////////////////////////////
   nice_rowbuf #(
      .row_len (row_len)
   ) u_nice_rowbuf (
      .nice_clk           (nice_clk),
      .nice_rst_n         (nice_rst_n),
      .load_wr            (load_wr),
      .sum_wr             (sum_wr),
      .wr_idx             (wr_idx),
      .nice_icb_rsp_rdata (nice_icb_rsp_rdata),
      .rd_idx             (rd_idx),
      .rd_data            (nice_icb_cmd_wdata),
      .row_sum            (row_sum)
   );

   // word accesses only, responses never back-pressured
   assign nice_icb_cmd_size  = nice_icb_pkg::SIZE_WORD;
   assign nice_icb_rsp_ready = 1'b1;

endmodule

`default_nettype wire

//--- hdl/nice_icb_pkg.sv
// nice icb package: memory bus address width, access size and word step
`default_nettype none

package nice_icb_pkg;

   // memory address width
   localparam int unsigned ADDR_W = 32;

   // icb size code for a full 32-bit word
   localparam logic [1:0] SIZE_WORD = 2'b10;

   // byte step from one row word to the next
   localparam logic [ADDR_W-1:0] WORD_BYTES = 32'd4;

endpackage

`default_nettype wire

//--- hdl/nice_isa_pkg.sv
// nice isa package: custom-3 instruction encodings, data width and operation codes
`default_nettype none

package nice_isa_pkg;

   // data word width of the core and the coprocessor
   localparam int unsigned XLEN = 32;

   // custom-3 major opcode, r-type only
   localparam logic [6:0] OPC_CUSTOM3 = 7'b1111011;

   // funct3 codes, lbuf and sbuf share one
   localparam logic [2:0] F3_BUF    = 3'b010;
   localparam logic [2:0] F3_ROWSUM = 3'b110;

   // funct7 codes select the operation
   localparam logic [6:0] F7_LBUF   = 7'b0000001;
   localparam logic [6:0] F7_SBUF   = 7'b0000010;
   localparam logic [6:0] F7_ROWSUM = 7'b0000110;

   // decoded operation, op_none marks an unsupported instruction
   typedef enum logic [1:0] {
      op_none,
      op_lbuf,
      op_sbuf,
      op_rowsum
   } nice_op_e;

endpackage

`default_nettype wire

//--- hdl/nice_rowbuf.sv
// nice row buffer: row word registers and row-sum accumulator fed from icb read data
`timescale 1ns/1ps
`default_nettype none

module nice_rowbuf #(
   parameter int unsigned row_len = 3,
   localparam int unsigned idx_w = (row_len > 1) ? $clog2(row_len) : 1
) (
   input  wire logic                            nice_clk,
   input  wire logic                            nice_rst_n,
   // write side, one strobe per memory response
   input  wire logic                            load_wr,
   input  wire logic                            sum_wr,
   input  wire logic [idx_w-1:0]                wr_idx,
   input  wire logic [nice_isa_pkg::XLEN-1:0]   nice_icb_rsp_rdata,
   // read side for store commands
   input  wire logic [idx_w-1:0]                rd_idx,
   output logic [nice_isa_pkg::XLEN-1:0]        rd_data,
   output logic [nice_isa_pkg::XLEN-1:0]        row_sum
);

   logic [nice_isa_pkg::XLEN-1:0] rows [row_len];
   logic [nice_isa_pkg::XLEN-1:0] acc_r;

   ////////////////////////////////////////////////////////////////////////////
   // row entries
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         for (int i = 0; i < row_len; i++) begin
            rows[i] <= '0;
         end
      end else if (load_wr) begin
         // lbuf replaces the entry
         rows[wr_idx] <= nice_icb_rsp_rdata;
      end else if (sum_wr) begin
         // rowsum folds the column value in, wraps at xlen
         rows[wr_idx] <= rows[wr_idx] + nice_icb_rsp_rdata;
      end
   end

   // index past the row end reads zero
   assign rd_data = (rd_idx < row_len) ? rows[rd_idx] : '0;

   ////////////////////////////////////////////////////////////////////////////
   // row-sum accumulator
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge nice_clk) begin
      if (sum_wr) begin
         // word 0 starts a new sum
         if (wr_idx == '0) begin
            acc_r <= nice_icb_rsp_rdata;
         end else begin
            acc_r <= acc_r + nice_icb_rsp_rdata;
         end
      end
   end

   assign row_sum = acc_r;

endmodule

`default_nettype wire

//--- hdl/nice_seq.sv
// nice sequencer: request decode, operation fsm, memory command issue and response build
`timescale 1ns/1ps
`default_nettype none

module nice_seq #(
   parameter int unsigned row_len = 3,
   localparam int unsigned idx_w = (row_len > 1) ? $clog2(row_len) : 1
) (
   input  wire logic                                nice_clk,
   input  wire logic                                nice_rst_n,
   // request channel from the core
   input  wire logic                                nice_req_valid,
   output logic                                     nice_req_ready,
   input  wire logic [nice_isa_pkg::XLEN-1:0]       nice_req_inst,
   input  wire logic [nice_isa_pkg::XLEN-1:0]       nice_req_rs1,
   // response channel to the core
   output logic                                     nice_rsp_valid,
   input  wire logic                                nice_rsp_ready,
   output logic [nice_isa_pkg::XLEN-1:0]            nice_rsp_rdat,
   output logic                                     nice_rsp_err,
   // icb command and response
   output logic                                     nice_icb_cmd_valid,
   input  wire logic                                nice_icb_cmd_ready,
   output logic [nice_icb_pkg::ADDR_W-1:0]          nice_icb_cmd_addr,
   output logic                                     nice_icb_cmd_read,
   input  wire logic                                nice_icb_rsp_valid,
   input  wire logic                                nice_icb_rsp_err,
   // row buffer steering
   output logic                                     load_wr,
   output logic                                     sum_wr,
   output logic [idx_w-1:0]                         wr_idx,
   output logic [idx_w-1:0]                         rd_idx,
   input  wire logic [nice_isa_pkg::XLEN-1:0]       row_sum,
   // core status
   output logic                                     nice_active,
   output logic                                     nice_mem_holdup
);

   // command counter must reach row_len itself
   localparam int unsigned cnt_w = $clog2(row_len + 1);

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_run  = 2'd1;
   localparam logic [1:0] st_rsp  = 2'd2;

   logic [1:0]                        state;
   nice_isa_pkg::nice_op_e            dec_op;
   nice_isa_pkg::nice_op_e            op_r;
   logic [nice_icb_pkg::ADDR_W-1:0]   base_r;
   logic [nice_icb_pkg::ADDR_W-1:0]   word_off;
   logic [cnt_w-1:0]                  cmd_cnt;
   logic [idx_w-1:0]                  rsp_cnt;
   logic                              err_r;
   logic                              req_hsk;
   logic                              rsp_hsk;
   logic                              cmd_hsk;
   logic                              mem_rsp;
   logic                              mem_rsp_last;

   ////////////////////////////////////////////////////////////////////////////
   // instruction decode
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      dec_op = nice_isa_pkg::op_none;
      if (nice_req_inst[6:0] == nice_isa_pkg::OPC_CUSTOM3) begin
         // funct3 picks the group, funct7 the operation inside it
         if (nice_req_inst[14:12] == nice_isa_pkg::F3_BUF) begin
            if (nice_req_inst[31:25] == nice_isa_pkg::F7_LBUF) begin
               dec_op = nice_isa_pkg::op_lbuf;
            end else if (nice_req_inst[31:25] == nice_isa_pkg::F7_SBUF) begin
               dec_op = nice_isa_pkg::op_sbuf;
            end
         end else if (nice_req_inst[14:12] == nice_isa_pkg::F3_ROWSUM &&
                      nice_req_inst[31:25] == nice_isa_pkg::F7_ROWSUM) begin
            dec_op = nice_isa_pkg::op_rowsum;
         end
      end
   end

   // handshakes, icb response side is always ready
   assign req_hsk      = nice_req_valid & nice_req_ready;
   assign rsp_hsk      = nice_rsp_valid & nice_rsp_ready;
   assign cmd_hsk      = nice_icb_cmd_valid & nice_icb_cmd_ready;
   assign mem_rsp      = (state == st_run) & nice_icb_rsp_valid;
   assign mem_rsp_last = mem_rsp & (rsp_cnt == idx_w'(row_len - 1));

   ////////////////////////////////////////////////////////////////////////////
   // operation fsm
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               // unsupported instruction goes straight to the error response
               if (req_hsk) begin
                  state <= (dec_op == nice_isa_pkg::op_none) ? st_rsp : st_run;
               end
            end
            st_run: begin
               if (mem_rsp_last) begin
                  state <= st_rsp;
               end
            end
            st_rsp: begin
               if (rsp_hsk) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // operation and sticky error, both captured at acceptance
   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         op_r  <= nice_isa_pkg::op_none;
         err_r <= 1'b0;
      end else if (req_hsk) begin
         op_r  <= dec_op;
         err_r <= (dec_op == nice_isa_pkg::op_none);
      end else if (mem_rsp & nice_icb_rsp_err) begin
         // any bad beat in the row marks the whole operation
         err_r <= 1'b1;
      end
   end

   // row base address
   always_ff @(posedge nice_clk) begin
      if (req_hsk) begin
         base_r <= nice_req_rs1[nice_icb_pkg::ADDR_W-1:0];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // command and response counters
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         cmd_cnt <= '0;
         rsp_cnt <= '0;
      end else if (req_hsk) begin
         cmd_cnt <= '0;
         rsp_cnt <= '0;
      end else begin
         if (cmd_hsk) begin
            cmd_cnt <= cmd_cnt + 1'b1;
         end
         // responses come back in order, so the count is the word index
         if (mem_rsp) begin
            rsp_cnt <= mem_rsp_last ? '0 : rsp_cnt + 1'b1;
         end
      end
   end

   // icb command, fields hold while cmd_ready is low
   assign word_off           = {{(nice_icb_pkg::ADDR_W - cnt_w){1'b0}}, cmd_cnt};
   assign nice_icb_cmd_valid = (state == st_run) & (cmd_cnt != cnt_w'(row_len));
   assign nice_icb_cmd_addr  = base_r + word_off * nice_icb_pkg::WORD_BYTES;
   assign nice_icb_cmd_read  = (op_r != nice_isa_pkg::op_sbuf);

   // row buffer steering
   assign load_wr = mem_rsp & (op_r == nice_isa_pkg::op_lbuf);
   assign sum_wr  = mem_rsp & (op_r == nice_isa_pkg::op_rowsum);
   assign wr_idx  = rsp_cnt;
   assign rd_idx  = cmd_cnt[idx_w-1:0];

   ////////////////////////////////////////////////////////////////////////////
   // core side
   ////////////////////////////////////////////////////////////////////////////
   assign nice_req_ready  = (state == st_idle);
   assign nice_rsp_valid  = (state == st_rsp);
   // only rowsum returns a value
   assign nice_rsp_rdat   = (op_r == nice_isa_pkg::op_rowsum) ? row_sum : '0;
   assign nice_rsp_err    = err_r;
   assign nice_active     = (state == st_idle) ? nice_req_valid : 1'b1;
   assign nice_mem_holdup = (state != st_idle);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the nice coprocessor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f \
   --top-module tb_nice_core -o tb_nice_core

./obj_dir/tb_nice_core | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
   exit 1
fi
exit 0

//--- sim/tb_nice_core.sv
// nice coprocessor testbench: random instruction stream checked against a row and memory model
`timescale 1ns/1ps
`default_nettype none

module tb_nice_core;

   localparam int unsigned row_len   = 3;
   localparam int unsigned n_random  = 40;
   localparam int unsigned wait_max  = 200;
   localparam logic [31:0] win_base  = 32'h0000_1000;
   localparam int unsigned win_words = 64;
   // words from here to the window end answer with an error
   localparam int unsigned err_first = 56;

   logic                                nice_clk;
   logic                                nice_rst_n;
   logic                                nice_active;
   logic                                nice_mem_holdup;
   logic                                nice_req_valid;
   logic                                nice_req_ready;
   logic [nice_isa_pkg::XLEN-1:0]       nice_req_inst;
   logic [nice_isa_pkg::XLEN-1:0]       nice_req_rs1;
   logic                                nice_rsp_valid;
   logic                                nice_rsp_ready;
   logic [nice_isa_pkg::XLEN-1:0]       nice_rsp_rdat;
   logic                                nice_rsp_err;
   logic                                nice_icb_cmd_valid;
   logic                                nice_icb_cmd_ready;
   logic [nice_icb_pkg::ADDR_W-1:0]     nice_icb_cmd_addr;
   logic                                nice_icb_cmd_read;
   logic [nice_isa_pkg::XLEN-1:0]       nice_icb_cmd_wdata;
   logic [1:0]                          nice_icb_cmd_size;
   logic                                nice_icb_rsp_valid;
   logic                                nice_icb_rsp_ready;
   logic [nice_isa_pkg::XLEN-1:0]       nice_icb_rsp_rdata;
   logic                                nice_icb_rsp_err;

   // reference model state
   logic [nice_isa_pkg::XLEN-1:0]       model_mem [win_words];
   logic [nice_isa_pkg::XLEN-1:0]       model_row [row_len];
   nice_isa_pkg::nice_op_e              exp_op;
   logic [31:0]                         exp_base;
   int                                  cmd_seen;
   int                                  rsp_taken;
   logic [31:0]                         lcg_state;

   nice_core #(
      .row_len (row_len)
   ) u_nice_core (
      .nice_clk           (nice_clk),
      .nice_rst_n         (nice_rst_n),
      .nice_active        (nice_active),
      .nice_mem_holdup    (nice_mem_holdup),
      .nice_req_valid     (nice_req_valid),
      .nice_req_ready     (nice_req_ready),
      .nice_req_inst      (nice_req_inst),
      .nice_req_rs1       (nice_req_rs1),
      .nice_rsp_valid     (nice_rsp_valid),
      .nice_rsp_ready     (nice_rsp_ready),
      .nice_rsp_rdat      (nice_rsp_rdat),
      .nice_rsp_err       (nice_rsp_err),
      .nice_icb_cmd_valid (nice_icb_cmd_valid),
      .nice_icb_cmd_ready (nice_icb_cmd_ready),
      .nice_icb_cmd_addr  (nice_icb_cmd_addr),
      .nice_icb_cmd_read  (nice_icb_cmd_read),
      .nice_icb_cmd_wdata (nice_icb_cmd_wdata),
      .nice_icb_cmd_size  (nice_icb_cmd_size),
      .nice_icb_rsp_valid (nice_icb_rsp_valid),
      .nice_icb_rsp_ready (nice_icb_rsp_ready),
      .nice_icb_rsp_rdata (nice_icb_rsp_rdata),
      .nice_icb_rsp_err   (nice_icb_rsp_err)
   );

   tb_nice_mem #(
      .base_addr (win_base),
      .depth     (win_words),
      .err_first (err_first)
   ) u_mem (
      .nice_clk   (nice_clk),
      .nice_rst_n (nice_rst_n),
      .cmd_valid  (nice_icb_cmd_valid),
      .cmd_ready  (nice_icb_cmd_ready),
      .cmd_addr   (nice_icb_cmd_addr),
      .cmd_read   (nice_icb_cmd_read),
      .cmd_wdata  (nice_icb_cmd_wdata),
      .rsp_valid  (nice_icb_rsp_valid),
      .rsp_ready  (nice_icb_rsp_ready),
      .rsp_rdata  (nice_icb_rsp_rdata),
      .rsp_err    (nice_icb_rsp_err)
   );

   initial begin
      nice_clk = 1'b0;
      forever #10 nice_clk = ~nice_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state ^ (lcg_state >> 15);
   endfunction

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input logic [nice_isa_pkg::XLEN-1:0] got,
                             input logic [nice_isa_pkg::XLEN-1:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_on_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   // r-type word with random register fields
   function automatic logic [31:0] make_inst(input nice_isa_pkg::nice_op_e op,
                                             input logic [31:0] r);
      logic [31:0] inst;
      inst      = r;
      inst[6:0] = nice_isa_pkg::OPC_CUSTOM3;
      case (op)
         nice_isa_pkg::op_lbuf: begin
            inst[14:12] = nice_isa_pkg::F3_BUF;
            inst[31:25] = nice_isa_pkg::F7_LBUF;
         end
         nice_isa_pkg::op_sbuf: begin
            inst[14:12] = nice_isa_pkg::F3_BUF;
            inst[31:25] = nice_isa_pkg::F7_SBUF;
         end
         nice_isa_pkg::op_rowsum: begin
            inst[14:12] = nice_isa_pkg::F3_ROWSUM;
            inst[31:25] = nice_isa_pkg::F7_ROWSUM;
         end
         default: begin
            // rowsum group with a buffer funct7 and sometimes the custom-1 opcode
            inst[14:12] = nice_isa_pkg::F3_ROWSUM;
            inst[31:25] = nice_isa_pkg::F7_LBUF;
            if (r[0]) begin
               inst[6:0] = 7'b0101011;
            end
         end
      endcase
      return inst;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // bus monitor
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge nice_clk) begin
      if (nice_rst_n && nice_icb_rsp_valid && nice_icb_rsp_ready) begin
         rsp_taken = rsp_taken + 1;
      end
      // a request about to be taken makes the coprocessor active
      if (nice_rst_n && nice_req_valid && nice_req_ready) begin
         check_bit("nice_active", nice_active, 1'b1);
      end
      if (nice_rst_n && nice_icb_cmd_valid && nice_icb_cmd_ready) begin
         if (exp_op == nice_isa_pkg::op_none || cmd_seen >= row_len) begin
            stop_on_error("memory command issued outside a supported operation");
         end else begin
            check_word("nice_icb_cmd_addr", nice_icb_cmd_addr, exp_base + 32'(cmd_seen) * 4);
            check_bit("nice_icb_cmd_read", nice_icb_cmd_read,
                      exp_op != nice_isa_pkg::op_sbuf);
            check_word("nice_icb_cmd_size", 32'(nice_icb_cmd_size),
                       32'(nice_icb_pkg::SIZE_WORD));
            // store data is the row before the operation
            if (exp_op == nice_isa_pkg::op_sbuf) begin
               check_word("nice_icb_cmd_wdata", nice_icb_cmd_wdata, model_row[cmd_seen]);
            end
            cmd_seen = cmd_seen + 1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // one operation entered and left on a falling edge
   ////////////////////////////////////////////////////////////////////////////
   task automatic run_op(input nice_isa_pkg::nice_op_e op, input logic [31:0] addr);
      logic [nice_isa_pkg::XLEN-1:0] new_row [row_len];
      logic [nice_isa_pkg::XLEN-1:0] word;
      logic [nice_isa_pkg::XLEN-1:0] exp_rdat;
      logic                          exp_err;
      logic                          done;
      int unsigned                   idx;
      int                            tmo;
      exp_rdat = '0;
      exp_err  = (op == nice_isa_pkg::op_none);
      // expected result from the model before the operation
      for (int k = 0; k < row_len; k++) begin
         idx        = (addr - win_base) / 4 + k;
         new_row[k] = model_row[k];
         if (op != nice_isa_pkg::op_none) begin
            if (idx >= err_first) begin
               exp_err = 1'b1;
            end
            // error words read back as zero
            word = (idx >= err_first) ? '0 : model_mem[idx];
            if (op == nice_isa_pkg::op_lbuf) begin
               new_row[k] = word;
            end else if (op == nice_isa_pkg::op_rowsum) begin
               new_row[k] = model_row[k] + word;
               exp_rdat   = exp_rdat + word;
            end
         end
      end
      exp_op         = op;
      exp_base       = addr;
      cmd_seen       = 0;
      rsp_taken      = 0;
      nice_req_inst  = make_inst(op, next_rand());
      nice_req_rs1   = addr;
      nice_req_valid = 1'b1;
      tmo = 0;
      while (!nice_req_ready) begin
         @(negedge nice_clk);
         tmo++;
         if (tmo > wait_max) begin
            stop_on_error("timeout waiting for the request to be accepted");
         end
      end
      @(negedge nice_clk);
      nice_req_valid = 1'b0;
      nice_req_inst  = next_rand();
      nice_req_rs1   = next_rand();
      done = 1'b0;
      tmo  = 0;
      while (!done) begin
         check_bit("nice_mem_holdup", nice_mem_holdup, 1'b1);
         check_bit("nice_active", nice_active, 1'b1);
         check_bit("nice_icb_rsp_ready", nice_icb_rsp_ready, 1'b1);
         // unsupported answers at once and the others right after the last memory response
         check_bit("nice_rsp_valid", nice_rsp_valid,
                   (op == nice_isa_pkg::op_none) || (rsp_taken == row_len));
         if (nice_rsp_valid) begin
            // response must hold steady through rsp_ready stalls
            check_word("nice_rsp_rdat", nice_rsp_rdat, exp_rdat);
            check_bit("nice_rsp_err", nice_rsp_err, exp_err);
            check_bit("nice_req_ready", nice_req_ready, 1'b0);
            check_word("memory command count", 32'(cmd_seen),
                       (op == nice_isa_pkg::op_none) ? 32'd0 : 32'(row_len));
            nice_rsp_ready = (next_rand() % 3) != 0;
            done           = nice_rsp_ready;
         end
         @(negedge nice_clk);
         tmo++;
         if (!done && tmo > wait_max) begin
            stop_on_error("timeout waiting for the response");
         end
      end
      nice_rsp_ready = 1'b0;
      check_bit("nice_rsp_valid", nice_rsp_valid, 1'b0);
      check_bit("nice_req_ready", nice_req_ready, 1'b1);
      check_bit("nice_mem_holdup", nice_mem_holdup, 1'b0);
      check_bit("nice_active", nice_active, 1'b0);
      // commit the model while stores skip the error region
      for (int k = 0; k < row_len; k++) begin
         idx = (addr - win_base) / 4 + k;
         if (op == nice_isa_pkg::op_sbuf && idx < err_first) begin
            model_mem[idx] = model_row[k];
            check_word("tb_nice_mem word", u_mem.mem[idx], model_mem[idx]);
         end
         model_row[k] = new_row[k];
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      nice_isa_pkg::nice_op_e op;
      logic [31:0]            r;
      lcg_state      = 32'd65;
      nice_rst_n     = 1'b0;
      nice_req_valid = 1'b0;
      nice_req_inst  = '0;
      nice_req_rs1   = '0;
      nice_rsp_ready = 1'b0;
      exp_op         = nice_isa_pkg::op_none;
      exp_base       = '0;
      cmd_seen       = 0;
      rsp_taken      = 0;
      repeat (10) @(negedge nice_clk);
      nice_rst_n = 1'b1;
      @(negedge nice_clk);
      check_bit("nice_req_ready", nice_req_ready, 1'b1);
      check_bit("nice_rsp_valid", nice_rsp_valid, 1'b0);
      check_bit("nice_icb_cmd_valid", nice_icb_cmd_valid, 1'b0);
      check_bit("nice_mem_holdup", nice_mem_holdup, 1'b0);
      check_bit("nice_active", nice_active, 1'b0);
      for (int i = 0; i < win_words; i++) begin
         model_mem[i] = u_mem.mem[i];
      end
      for (int k = 0; k < row_len; k++) begin
         model_row[k] = '0;
      end
      // load and store then rowsum and a store of the summed row
      run_op(nice_isa_pkg::op_lbuf, win_base + 32'h20);
      run_op(nice_isa_pkg::op_sbuf, win_base + 32'h60);
      run_op(nice_isa_pkg::op_rowsum, win_base + 32'h40);
      run_op(nice_isa_pkg::op_sbuf, win_base + 32'h60);
      run_op(nice_isa_pkg::op_none, win_base);
      // row straddling the start of the error region
      run_op(nice_isa_pkg::op_lbuf, win_base + 32'((err_first - 1) * 4));
      for (int n = 0; n < n_random; n++) begin
         r  = next_rand() % 8;
         op = (r == 0) ? nice_isa_pkg::op_none :
              (r < 3)  ? nice_isa_pkg::op_lbuf :
              (r < 5)  ? nice_isa_pkg::op_sbuf : nice_isa_pkg::op_rowsum;
         run_op(op, win_base + 32'((next_rand() % (win_words - row_len + 1)) * 4));
      end
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/tb_nice_mem.sv
// icb memory model with random command stalls, in-order delayed responses and an error region
`timescale 1ns/1ps
`default_nettype none

module tb_nice_mem #(
   parameter logic [31:0] base_addr = 32'h0000_1000,
   parameter int unsigned depth     = 64,
   parameter int unsigned err_first = 56,
   parameter logic [31:0] seed      = 32'd65
) (
   input  wire logic                                nice_clk,
   input  wire logic                                nice_rst_n,
   input  wire logic                                cmd_valid,
   output logic                                     cmd_ready,
   input  wire logic [nice_icb_pkg::ADDR_W-1:0]     cmd_addr,
   input  wire logic                                cmd_read,
   input  wire logic [nice_isa_pkg::XLEN-1:0]       cmd_wdata,
   output logic                                     rsp_valid,
   input  wire logic                                rsp_ready,
   output logic [nice_isa_pkg::XLEN-1:0]            rsp_rdata,
   output logic                                     rsp_err
);

   logic [nice_isa_pkg::XLEN-1:0] mem [depth];
   // pending responses, oldest first
   logic [nice_isa_pkg::XLEN-1:0] q_data [$];
   logic                          q_err [$];
   int                            q_due [$];
   int                            cyc;
   logic [31:0]                   lcg_state;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state ^ (lcg_state >> 15);
   endfunction

   // every bit of the address shapes the word
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
   endfunction

   initial begin
      lcg_state = seed;
      for (int i = 0; i < depth; i++) begin
         mem[i] = fill_word(base_addr + 32'(i) * 32'd4);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // command side, transfers and responses are taken on the rising edge
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge nice_clk or negedge nice_rst_n) begin
      int unsigned idx;
      logic        bad;
      int          due;
      if (!nice_rst_n) begin
         cyc = 0;
         q_data.delete();
         q_err.delete();
         q_due.delete();
      end else begin
         cyc = cyc + 1;
         if (rsp_valid && rsp_ready) begin
            void'(q_data.pop_front());
            void'(q_err.pop_front());
            void'(q_due.pop_front());
         end
         if (cmd_valid && cmd_ready) begin
            idx = (cmd_addr - base_addr) >> 2;
            // outside the window or inside the error region
            bad = (cmd_addr < base_addr) || (idx >= err_first);
            if (!cmd_read && !bad) begin
               mem[idx] = cmd_wdata;
            end
            q_data.push_back((cmd_read && !bad) ? mem[idx] : '0);
            q_err.push_back(bad);
            // random latency, never overtaking an older response
            due = cyc + int'(next_rand() % 4);
            if (q_due.size() != 0 && due < q_due[$]) begin
               due = q_due[$];
            end
            q_due.push_back(due);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // outputs change on the falling edge
   ////////////////////////////////////////////////////////////////////////////
   always @(negedge nice_clk or negedge nice_rst_n) begin
      if (!nice_rst_n) begin
         cmd_ready <= 1'b0;
         rsp_valid <= 1'b0;
         rsp_rdata <= '0;
         rsp_err   <= 1'b0;
      end else begin
         // stall roughly one command slot in four
         cmd_ready <= (next_rand() % 4) != 0;
         if (q_due.size() != 0 && q_due[0] <= cyc) begin
            rsp_valid <= 1'b1;
            rsp_rdata <= q_data[0];
            rsp_err   <= q_err[0];
         end else begin
            rsp_valid <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire
